//--- bench/ray_plane_tb.sv
`timescale 1ns/1ps

module ray_plane_tb import ray_plane_pkg::*; ();

    localparam int FRAC_W         = 16;  // Table t values are in 16.16 form
    localparam int NUM_TBL        = 6;
    localparam int NUM_RAND       = 40;
    localparam int RUN_LIMIT      = 100 + QUOT_W;  // Cycles allowed per query
    localparam int TIMEOUT_CYCLES = 16 + (NUM_TBL + NUM_RAND + 3) * RUN_LIMIT;

    logic        clk;
    logic        rst_n;
    logic        start_i;
    ray_query_t  query_i;
    logic        busy_o;
    logic        done_o;
    hit_result_t result_o;

    ray_query_t  tbl_q[NUM_TBL];
    hit_result_t tbl_e[NUM_TBL];
    string       tbl_name[NUM_TBL];
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          cycles = 0;

    ray_plane_top #(
        .FRAC_W (FRAC_W)
    ) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (start_i),
        .query_i  (query_i),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .result_o (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // Helpers and reference model
    // --------------------------------------------------
    task automatic step();
        @(posedge clk);
        #1;  // Drive and sample just after the edge
    endtask

    task automatic check_result(input string what, input hit_result_t got, input hit_result_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t: %s got hit=%0b t=%0d pt=(%0d,%0d,%0d)", $time, what,
                     got.hit, got.t, got.point.x, got.point.y, got.point.z);
            $display("[ERROR] %0t: %s expected hit=%0b t=%0d pt=(%0d,%0d,%0d)", $time, what,
                     exp.hit, exp.t, exp.point.x, exp.point.y, exp.point.z);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("PASS  %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL  %s", name);
        end
    endtask

    function automatic vec3_t v3(input int x, input int y, input int z);
        return '{coord_t'(x), coord_t'(y), coord_t'(z)};
    endfunction

    function automatic hit_result_t hit_at(input longint t, input int x, input int y, input int z);
        return '{1'b1, word_t'(t), '{point_t'(x), point_t'(y), point_t'(z)}};
    endfunction

    function automatic longint comp(input vec3_t v, input int i);
        coord_t c;
        c = (i == 0) ? v.x : (i == 1) ? v.y : v.z;
        return longint'(c);
    endfunction

    function automatic hit_result_t expected_result(input ray_query_t q);
        longint          ab[3], ac[3], pr[3], n[3];
        longint          num, den, t;
        longint unsigned mag;
        hit_result_t     r;
        num = 0;
        den = 0;
        r   = '0;
        for (int i = 0; i < 3; i++) begin
            ab[i] = comp(q.p1, i) - comp(q.p0, i);
            ac[i] = comp(q.p2, i) - comp(q.p0, i);
            pr[i] = comp(q.p0, i) - comp(q.r0, i);
        end
        n[0] = ab[1] * ac[2] - ab[2] * ac[1];  // Plane normal AB x AC
        n[1] = ab[2] * ac[0] - ab[0] * ac[2];
        n[2] = ab[0] * ac[1] - ab[1] * ac[0];
        for (int i = 0; i < 3; i++) begin
            num += pr[i] * n[i];
            den += comp(q.rd, i) * n[i];
        end
        if (den == 0) return r;  // Parallel ray
        mag = (num < 0) ? -num : num;
        mag = (mag << FRAC_W) / ((den < 0) ? -den : den);
        t   = ((num < 0) != (den < 0)) ? -longint'(mag) : longint'(mag);
        if (t <= 0) return r;
        r.hit     = 1'b1;
        r.t       = t;
        r.point.x = point_t'(((t * comp(q.rd, 0)) >>> FRAC_W) + comp(q.r0, 0));
        r.point.y = point_t'(((t * comp(q.rd, 1)) >>> FRAC_W) + comp(q.r0, 1));
        r.point.z = point_t'(((t * comp(q.rd, 2)) >>> FRAC_W) + comp(q.r0, 2));
        return r;
    endfunction

    function automatic vec3_t rand_vec(input int span);
        int x, y, z;
        x = int'($urandom_range(2 * span)) - span;
        y = int'($urandom_range(2 * span)) - span;
        z = int'($urandom_range(2 * span)) - span;
        return v3(x, y, z);
    endfunction

    task automatic load_table();
        vec3_t a0, a1, a2;
        a0 = v3(0, 0, 10);  // Triangle in plane z = 10
        a1 = v3(10, 0, 10);
        a2 = v3(0, 10, 10);
        tbl_name[0] = "axis ray hit";
        tbl_q[0]    = '{a0, a1, a2, v3(1, 1, 0), v3(0, 0, 2)};
        tbl_e[0]    = hit_at(327680, 1, 1, 10);
        tbl_name[1] = "oblique ray hit, fractional t";
        tbl_q[1]    = '{a0, a1, a2, v3(2, 3, 1), v3(1, 2, 7)};
        tbl_e[1]    = hit_at(84260, 3, 5, 9);
        tbl_name[2] = "ray pointing away";
        tbl_q[2]    = '{a0, a1, a2, v3(1, 1, 0), v3(0, 0, -2)};
        tbl_e[2]    = '0;
        tbl_name[3] = "ray parallel to plane";
        tbl_q[3]    = '{a0, a1, a2, v3(1, 1, 0), v3(1, 0, 0)};
        tbl_e[3]    = '0;
        tbl_name[4] = "origin on plane, t zero";
        tbl_q[4]    = '{a0, a1, a2, v3(1, 1, 10), v3(0, 0, 1)};
        tbl_e[4]    = '0;
        tbl_name[5] = "downward normal hit";
        tbl_q[5]    = '{v3(0, 0, -10), v3(0, 10, -10), v3(10, 0, -10), v3(3, 4, 5), v3(0, 0, -1)};
        tbl_e[5]    = hit_at(983040, 3, 4, -10);
    endtask

    // One start pulse, then wait for done while watching the held result
    task automatic run_query(input ray_query_t q, output hit_result_t got, output logic held);
        hit_result_t prev;
        prev    = result_o;
        held    = 1'b1;
        query_i = q;
        start_i = 1'b1;
        step();
        start_i = 1'b0;
        while (done_o !== 1'b1) begin
            if (result_o !== prev) held = 1'b0;
            step();
        end
        got = result_o;
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        hit_result_t got;
        hit_result_t exp;
        ray_query_t  q;
        logic        held;
        int          errs;
        int          extra;
        void'($urandom(32'h66bb8885));
        err_cnt  = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        rst_n    = 1'b0;
        start_i  = 1'b0;
        query_i  = '0;
        load_table();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();

        errs = err_cnt;
        check_flag("busy_o after reset", busy_o, 1'b0);
        check_flag("done_o after reset", done_o, 1'b0);
        check_result("result_o after reset", result_o, '0);
        report_test("reset state", errs);

        for (int i = 0; i < NUM_TBL; i++) begin
            errs = err_cnt;
            run_query(tbl_q[i], got, held);
            check_flag({tbl_name[i], " hit flag"}, got.hit, tbl_e[i].hit);
            check_result(tbl_name[i], got, tbl_e[i]);
            report_test(tbl_name[i], errs);
        end

        // Second start lands mid-computation
        errs    = err_cnt;
        query_i = tbl_q[0];
        start_i = 1'b1;
        step();
        start_i = 1'b0;
        repeat (3) step();
        check_flag("busy_o before second start", busy_o, 1'b1);
        query_i = tbl_q[2];
        start_i = 1'b1;
        step();
        start_i = 1'b0;
        while (done_o !== 1'b1) step();
        check_result("start during busy", result_o, tbl_e[0]);
        extra = 0;
        repeat (RUN_LIMIT) begin
            step();
            if (done_o === 1'b1) extra++;
        end
        check_flag("no extra done_o after ignored start", extra == 0, 1'b1);
        report_test("start while busy ignored", errs);

        for (int n = 0; n < NUM_RAND; n++) begin
            errs = err_cnt;
            q    = '{rand_vec(60), rand_vec(60), rand_vec(60), rand_vec(60), rand_vec(20)};
            exp  = expected_result(q);
            run_query(q, got, held);
            check_flag("result_o held until done_o", held, 1'b1);
            check_result($sformatf("random %0d", n), got, exp);
            report_test($sformatf("random %0d (hit=%0b)", n, exp.hit), errs);
        end

        $display("Summary: %0d tests passed, %0d failed, %0d errors", pass_cnt, fail_cnt,
                 err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
src/ray_plane_pkg.sv
src/mac_lanes.sv
src/fx_divider.sv
src/plane_sequencer.sv
src/ray_plane_top.sv
bench/ray_plane_tb.sv

//--- src/fx_divider.sv
`timescale 1ns/1ps

module fx_divider import ray_plane_pkg::*; #(
    parameter int FRAC_W = 16
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start_i,
    input  word_t num_i,
    input  word_t den_i,
    output word_t quot_o,
    output logic  busy_o,
    output logic  done_o
);

    localparam int CNT_W = $clog2(QUOT_W + 1);

    logic [WORD_W-1:0] num_mag;
    logic [WORD_W-1:0] den_mag;
    logic [WORD_W-1:0] den_q;     // Divisor magnitude
    logic [WORD_W-1:0] quo_q;     // Dividend shifts out, quotient shifts in
    logic [WORD_W:0]   rem_q;
    logic [WORD_W:0]   shifted;
    logic [WORD_W:0]   trial;
    logic [CNT_W-1:0]  cnt_q;
    logic              neg_q;     // Sign of the result

    assign num_mag = num_i[WORD_W-1] ? -num_i : num_i;
    assign den_mag = den_i[WORD_W-1] ? -den_i : den_i;

    // Restoring step
    assign shifted = {rem_q[WORD_W-1:0], quo_q[WORD_W-1]};
    assign trial   = shifted - {1'b0, den_q};

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy_o <= 1'b1;
                cnt_q  <= CNT_W'(QUOT_W);
            end else if (busy_o) begin
                if (cnt_q != '0) begin
                    cnt_q <= cnt_q - 1'b1;
                end else begin
                    busy_o <= 1'b0;  // Sign fix-up cycle
                    done_o <= 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (start_i) begin
            den_q <= den_mag;
            quo_q <= num_mag << FRAC_W;  // Wraps to the word
            rem_q <= '0;
            neg_q <= num_i[WORD_W-1] ^ den_i[WORD_W-1];
        end else if (busy_o && cnt_q != '0) begin
            if (!trial[WORD_W]) begin
                rem_q <= trial;
                quo_q <= {quo_q[WORD_W-2:0], 1'b1};
            end else begin
                rem_q <= shifted;
                quo_q <= {quo_q[WORD_W-2:0], 1'b0};
            end
        end else if (busy_o) begin
            quot_o <= neg_q ? -quo_q : quo_q;  // Truncates toward zero
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> !busy_o);

    a_den_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> den_i != '0);

endmodule

//--- src/mac_lanes.sv
`timescale 1ns/1ps

module mac_lanes import ray_plane_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          go_i,
    input  lane_cmd_vec_t cmd_i,
    output lane_res_vec_t res_o,
    output logic          valid_o
);

    // --------------------------------------------------
    // One registered op per lane
    // --------------------------------------------------
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        always_ff @(posedge clk) begin
            if (go_i) begin
                case (cmd_i[i].op)
                    LANE_MUL: res_o[i] <= cmd_i[i].a * cmd_i[i].b; // Low word of product
                    LANE_ADD: res_o[i] <= cmd_i[i].b + cmd_i[i].c;
                    LANE_SUB: res_o[i] <= cmd_i[i].b - cmd_i[i].c;
                    default:  res_o[i] <= '0;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= go_i;
        end
    end

    // Issuer waits for the capture before the next step
    a_go_spaced: assert property (@(posedge clk) disable iff (!rst_n)
        go_i |=> !go_i);

endmodule

//--- src/plane_sequencer.sv
`timescale 1ns/1ps

module plane_sequencer import ray_plane_pkg::*; #(
    parameter int FRAC_W = 16
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start_i,
    input  ray_query_t    query_i,
    output logic          busy_o,
    output logic          done_o,
    output hit_result_t   result_o,
    output logic          lane_go_o,
    output lane_cmd_vec_t lane_cmd_o,
    input  lane_res_vec_t lane_res_i,
    input  logic          lane_valid_i,
    output logic          div_start_o,
    output word_t         div_num_o,
    output word_t         div_den_o,
    input  word_t         div_quot_i,
    input  logic          div_done_i
);

    // Lane steps run in enum order up to S_DECIDE
    typedef enum logic [3:0] {
        S_IDLE,
        S_VDIFF1,     // AB, AC
        S_VDIFF2,     // P0 - R0
        S_NORM_MUL,
        S_NORM_SUB,
        S_DOT_MUL,
        S_DOT_SUM1,
        S_DOT_SUM2,
        S_DECIDE,
        S_DIVIDE,
        S_POINT_MUL,
        S_POINT_ADD
    } state_t;

    state_t        state_q;
    logic          wait_q;    // Lane step issued and its capture pending
    logic          lane_step;
    ray_query_t    query_q;
    wvec3_t        p0w, p1w, p2w, r0w, rdw;
    wvec3_t        ab, ac, pr, nrm;
    lane_res_vec_t prod;      // Products and partial sums
    word_t         num_q, den_q, t_q;

    function automatic wvec3_t widen(vec3_t v);
        return '{word_t'(v.x), word_t'(v.y), word_t'(v.z)};
    endfunction

    function automatic word_t pick(wvec3_t v, int i);
        return (i == 0) ? v.x : (i == 1) ? v.y : v.z;
    endfunction

    function automatic lane_cmd_t mk_cmd(lane_op_t op, word_t a, word_t b, word_t c);
        return '{op: op, a: a, b: b, c: c};
    endfunction

    assign p0w = widen(query_q.p0);
    assign p1w = widen(query_q.p1);
    assign p2w = widen(query_q.p2);
    assign r0w = widen(query_q.r0);
    assign rdw = widen(query_q.rd);

    // --------------------------------------------------
    // Lane and divider issue
    // --------------------------------------------------
    assign lane_step = state_q inside {[S_VDIFF1:S_DOT_SUM2], S_POINT_MUL, S_POINT_ADD};
    assign lane_go_o = lane_step && !wait_q;

    assign div_start_o = (state_q == S_DECIDE) && (den_q != '0);
    assign div_num_o   = num_q;
    assign div_den_o   = den_q;

    always_comb begin
        lane_cmd_o = '0;
        case (state_q)
            S_VDIFF1: begin
                for (int i = 0; i < 3; i++) begin
                    lane_cmd_o[i]     = mk_cmd(LANE_SUB, '0, pick(p1w, i), pick(p0w, i));
                    lane_cmd_o[i + 3] = mk_cmd(LANE_SUB, '0, pick(p2w, i), pick(p0w, i));
                end
            end
            S_VDIFF2: begin
                for (int i = 0; i < 3; i++) begin
                    lane_cmd_o[i] = mk_cmd(LANE_SUB, '0, pick(p0w, i), pick(r0w, i));
                end
            end
            S_NORM_MUL: begin
                // Lane i holds the minuend of n[i] and lane i+3 its subtrahend
                for (int i = 0; i < 3; i++) begin
                    lane_cmd_o[i]     = mk_cmd(LANE_MUL, pick(ab, (i + 1) % 3),
                                               pick(ac, (i + 2) % 3), '0);
                    lane_cmd_o[i + 3] = mk_cmd(LANE_MUL, pick(ab, (i + 2) % 3),
                                               pick(ac, (i + 1) % 3), '0);
                end
            end
            S_NORM_SUB: begin
                for (int i = 0; i < 3; i++) begin
                    lane_cmd_o[i] = mk_cmd(LANE_SUB, '0, prod[i], prod[i + 3]);
                end
            end
            S_DOT_MUL: begin
                for (int i = 0; i < 3; i++) begin
                    lane_cmd_o[i]     = mk_cmd(LANE_MUL, pick(pr, i), pick(nrm, i), '0);
                    lane_cmd_o[i + 3] = mk_cmd(LANE_MUL, pick(rdw, i), pick(nrm, i), '0);
                end
            end
            S_DOT_SUM1: begin
                lane_cmd_o[0] = mk_cmd(LANE_ADD, '0, prod[0], prod[1]);
                lane_cmd_o[1] = mk_cmd(LANE_ADD, '0, prod[3], prod[4]);
            end
            S_DOT_SUM2: begin
                lane_cmd_o[0] = mk_cmd(LANE_ADD, '0, prod[0], prod[2]); // Numerator
                lane_cmd_o[1] = mk_cmd(LANE_ADD, '0, prod[3], prod[5]); // Denominator
            end
            S_POINT_MUL: begin
                for (int i = 0; i < 3; i++) begin
                    lane_cmd_o[i] = mk_cmd(LANE_MUL, t_q, pick(rdw, i), '0);
                end
            end
            S_POINT_ADD: begin
                for (int i = 0; i < 3; i++) begin
                    lane_cmd_o[i] = mk_cmd(LANE_ADD, '0, prod[i], pick(r0w, i));
                end
            end
            default: ;
        endcase
    end

    // --------------------------------------------------
    // Control FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= S_IDLE;
            wait_q   <= 1'b0;
            busy_o   <= 1'b0;
            done_o   <= 1'b0;
            result_o <= '0;
        end else begin
            done_o <= 1'b0;
            if (lane_go_o) wait_q <= 1'b1;
            if (lane_valid_i) wait_q <= 1'b0;

            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        busy_o  <= 1'b1;
                        state_q <= S_VDIFF1;
                    end
                end
                S_DECIDE: begin
                    if (den_q == '0) begin  // Ray parallel to the plane
                        result_o <= '0;
                        done_o   <= 1'b1;
                        busy_o   <= 1'b0;
                        state_q  <= S_IDLE;
                    end else begin
                        state_q <= S_DIVIDE;
                    end
                end
                S_DIVIDE: begin
                    if (div_done_i) begin
                        if (div_quot_i[WORD_W-1] || div_quot_i == '0) begin
                            result_o <= '0;  // Plane behind the origin
                            done_o   <= 1'b1;
                            busy_o   <= 1'b0;
                            state_q  <= S_IDLE;
                        end else begin
                            state_q <= S_POINT_MUL;
                        end
                    end
                end
                S_POINT_ADD: begin
                    if (lane_valid_i) begin
                        result_o.hit     <= 1'b1;
                        result_o.t       <= t_q;
                        result_o.point.x <= lane_res_i[0][POINT_W-1:0];
                        result_o.point.y <= lane_res_i[1][POINT_W-1:0];
                        result_o.point.z <= lane_res_i[2][POINT_W-1:0];
                        done_o           <= 1'b1;
                        busy_o           <= 1'b0;
                        state_q          <= S_IDLE;
                    end
                end
                default: begin
                    if (lane_valid_i) state_q <= state_t'(state_q + 4'd1);
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Operand and intermediate registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && start_i) query_q <= query_i;
        if (state_q == S_DIVIDE && div_done_i) t_q <= div_quot_i;

        if (lane_valid_i) begin
            case (state_q)
                S_VDIFF1: begin
                    ab <= '{lane_res_i[0], lane_res_i[1], lane_res_i[2]};
                    ac <= '{lane_res_i[3], lane_res_i[4], lane_res_i[5]};
                end
                S_VDIFF2:   pr  <= '{lane_res_i[0], lane_res_i[1], lane_res_i[2]};
                S_NORM_MUL: prod <= lane_res_i;
                S_NORM_SUB: nrm <= '{lane_res_i[0], lane_res_i[1], lane_res_i[2]};
                S_DOT_MUL:  prod <= lane_res_i;
                S_DOT_SUM1: begin
                    prod[0] <= lane_res_i[0];
                    prod[3] <= lane_res_i[1];
                end
                S_DOT_SUM2: begin
                    num_q <= lane_res_i[0];
                    den_q <= lane_res_i[1];
                end
                S_POINT_MUL: begin
                    for (int i = 0; i < 3; i++) begin
                        prod[i] <= $signed(lane_res_i[i]) >>> FRAC_W; // Drop t fraction
                    end
                end
                default: ;
            endcase
        end
    end

    // Each lane step captures exactly one cycle after issue
    a_lane_answer: assert property (@(posedge clk) disable iff (!rst_n)
        lane_go_o |=> lane_valid_i);

endmodule

//--- src/ray_plane_pkg.sv
package ray_plane_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int COORD_W   = 12;     // Input coordinate
    localparam int WORD_W    = 64;     // Every lane value, holds exact dot products
    localparam int POINT_W   = 32;     // Reported point coordinate
    localparam int NUM_LANES = 6;      // Two triple products of a cross product
    localparam int QUOT_W    = WORD_W; // Quotient bits, one per divider cycle

    typedef logic signed [COORD_W-1:0] coord_t;
    typedef logic signed [WORD_W-1:0]  word_t;
    typedef logic signed [POINT_W-1:0] point_t;

    // --------------------------------------------------
    // Vectors and query
    // --------------------------------------------------
    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vec3_t;

    typedef struct packed {
        word_t x;
        word_t y;
        word_t z;
    } wvec3_t;

    typedef struct packed {
        point_t x;
        point_t y;
        point_t z;
    } pvec3_t;

    // Triangle vertices, ray origin and direction
    typedef struct packed {
        vec3_t p0;
        vec3_t p1;
        vec3_t p2;
        vec3_t r0;
        vec3_t rd;
    } ray_query_t;

    // --------------------------------------------------
    // Lane commands
    // --------------------------------------------------
    typedef enum logic [1:0] {
        LANE_MUL = 2'd0,   // a * b
        LANE_ADD = 2'd1,   // b + c
        LANE_SUB = 2'd2    // b - c
    } lane_op_t;

    typedef struct packed {
        lane_op_t op;
        word_t    a;
        word_t    b;
        word_t    c;
    } lane_cmd_t;

    typedef lane_cmd_t [NUM_LANES-1:0] lane_cmd_vec_t;
    typedef word_t     [NUM_LANES-1:0] lane_res_vec_t;

    // t carries FRAC_W fraction bits, zero fields on a miss
    typedef struct packed {
        logic   hit;
        word_t  t;
        pvec3_t point;
    } hit_result_t;

endpackage

//--- src/ray_plane_top.sv
`timescale 1ns/1ps

module ray_plane_top import ray_plane_pkg::*; #(
    parameter int FRAC_W = 16   // Fraction bits of t, 8 to 20
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start_i,
    input  ray_query_t  query_i,
    output logic        busy_o,
    output logic        done_o,
    output hit_result_t result_o
);

    lane_cmd_vec_t lane_cmd;
    lane_res_vec_t lane_res;
    logic          lane_go;
    logic          lane_valid;
    logic          div_start;
    logic          div_done;
    word_t         div_num;
    word_t         div_den;
    word_t         div_quot;

    plane_sequencer #(
        .FRAC_W (FRAC_W)
    ) seq0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .query_i      (query_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .result_o     (result_o),
        .lane_go_o    (lane_go),
        .lane_cmd_o   (lane_cmd),
        .lane_res_i   (lane_res),
        .lane_valid_i (lane_valid),
        .div_start_o  (div_start),
        .div_num_o    (div_num),
        .div_den_o    (div_den),
        .div_quot_i   (div_quot),
        .div_done_i   (div_done)
    );

    mac_lanes lanes0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .go_i    (lane_go),
        .cmd_i   (lane_cmd),
        .res_o   (lane_res),
        .valid_o (lane_valid)
    );

    fx_divider #(
        .FRAC_W (FRAC_W)
    ) div0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (div_start),
        .num_i   (div_num),
        .den_i   (div_den),
        .quot_o  (div_quot),
        .busy_o  (),
        .done_o  (div_done)
    );

endmodule
